// File: src/icache_pkg.sv
// l1 icache shared types
// geometry, address fields, channel structs
`default_nettype none

package icache_pkg;

  // geometry
  localparam int ICACHE_WAYS       = 2;
  localparam int ICACHE_SETS       = 16;
  localparam int ICACHE_WORD_LEN   = 32;
  localparam int ICACHE_LINE_WORDS = 4;
  localparam int ICACHE_LINE_LEN   = ICACHE_WORD_LEN * ICACHE_LINE_WORDS;  // 128
  localparam int ADDR_LEN          = 32;
  localparam int OFFSET_LEN        = $clog2(ICACHE_LINE_LEN / 8);  // byte offset in line
  localparam int IDX_LEN           = $clog2(ICACHE_SETS);
  localparam int TAG_LEN           = ADDR_LEN - IDX_LEN - OFFSET_LEN;  // 24
  localparam int VTAG_LEN          = 1 + TAG_LEN;  // valid + tag
  localparam int WAY_IDX_LEN       = $clog2(ICACHE_WAYS);
  localparam int WORD_OFF_LEN      = $clog2(ICACHE_LINE_WORDS);
  localparam int LINE_ADDR_LEN     = ADDR_LEN - OFFSET_LEN;

  typedef logic [ADDR_LEN-1:0]        icache_addr_t;
  typedef logic [LINE_ADDR_LEN-1:0]   icache_laddr_t;   // upper 28 bits
  typedef logic [IDX_LEN-1:0]         icache_idx_t;
  typedef logic [TAG_LEN-1:0]         icache_tag_t;
  typedef logic [WORD_OFF_LEN-1:0]    icache_woff_t;
  typedef logic [WAY_IDX_LEN-1:0]     icache_way_t;
  typedef logic [ICACHE_WORD_LEN-1:0] icache_word_t;
  typedef icache_word_t [ICACHE_LINE_WORDS-1:0] icache_line_t;  // word 0 in low bits

  // address field extraction
  function automatic icache_idx_t addr_idx(icache_addr_t addr);
    return addr[OFFSET_LEN +: IDX_LEN];
  endfunction

  function automatic icache_tag_t addr_tag(icache_addr_t addr);
    return addr[ADDR_LEN-1 -: TAG_LEN];
  endfunction

  function automatic icache_woff_t addr_woff(icache_addr_t addr);
    return addr[OFFSET_LEN-1 -: WORD_OFF_LEN];  // skips byte-in-word bits
  endfunction

  typedef struct packed {
    logic        valid;
    icache_tag_t tag;
  } icache_vtag_t;

  typedef struct packed {
    logic         valid;
    icache_addr_t addr;
  } fetch_req_t;

  typedef struct packed {
    logic         valid;
    icache_word_t data;
  } fetch_resp_t;

  typedef struct packed {
    logic          valid;
    icache_laddr_t line_addr;
  } l2_req_t;

  typedef struct packed {
    logic         valid;
    icache_line_t line;
  } l2_resp_t;

  // per-way sram strobes
  typedef struct packed {
    logic [ICACHE_WAYS-1:0] tag_cs;
    logic [ICACHE_WAYS-1:0] tag_we;
    logic [ICACHE_WAYS-1:0] data_cs;
    logic [ICACHE_WAYS-1:0] data_we;
  } icache_mem_ctrl_t;

  typedef struct packed {
    logic         hit;
    icache_way_t  way;
    icache_word_t word;
  } icache_way_sel_t;

endpackage

`default_nettype wire

// File: src/ssram.sv
// single-port synchronous sram
`timescale 1ns/100ps
`default_nettype none

module ssram #(
  parameter int NUM_WORDS = 16,
  parameter int DATA_LEN  = 32
) (
  input  wire logic                         clk_i,
  input  wire logic                         cs_i,     // chip select
  input  wire logic                         we_i,     // write when selected
  input  wire logic [$clog2(NUM_WORDS)-1:0] addr_i,
  input  wire logic [DATA_LEN-1:0]          wdata_i,
  output logic      [DATA_LEN-1:0]          rdata_o   // registered read port
);

  // storage array
  logic [DATA_LEN-1:0] mem_q [NUM_WORDS];

  always_ff @(posedge clk_i) begin : mem_access
    if (cs_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;  // rdata_o keeps old value
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

// File: src/icache_way_select.sv
// icache way selector
// tag compare and hit word mux
`timescale 1ns/100ps
`default_nettype none

module icache_way_select
  import icache_pkg::*;
(
  input  wire icache_vtag_t [ICACHE_WAYS-1:0] vtag_i,     // per-way valid + tag
  input  wire icache_line_t [ICACHE_WAYS-1:0] line_i,     // per-way line read
  input  wire icache_tag_t                    req_tag_i,
  input  wire icache_woff_t                   req_word_i,
  output icache_way_sel_t                     way_sel_o
);

  logic [ICACHE_WAYS-1:0] hit_vec;
  icache_way_t            hit_way;
  icache_line_t           hit_line;

  always_comb begin : tag_cmp
    for (int w = 0; w < ICACHE_WAYS; w++) begin
      hit_vec[w] = vtag_i[w].valid && (vtag_i[w].tag == req_tag_i);
    end
  end

  // encoder, lowest hitting way wins
  always_comb begin : hit_enc
    hit_way = '0;
    for (int w = ICACHE_WAYS - 1; w >= 0; w--) begin
      if (hit_vec[w]) begin
        hit_way = icache_way_t'(w);
      end
    end
  end

  assign hit_line = line_i[hit_way];

  // word is don't-care when no way hits
  assign way_sel_o = '{
    hit:  |hit_vec,
    way:  hit_way,
    word: hit_line[req_word_i]
  };

endmodule

`default_nettype wire

// File: src/icache_ctrl.sv
// icache controller
// fsm, lru bits, flush sweep, sram strobes
`timescale 1ns/100ps
`default_nettype none

module icache_ctrl
  import icache_pkg::*;
(
  input  wire logic            clk_i,
  input  wire logic            arst_n_i,
  input  wire logic            flush_i,       // invalidate whole cache
  input  wire logic            abort_i,       // drop pending miss
  input  wire fetch_req_t      fetch_req_i,
  output logic                 ready_o,
  output fetch_resp_t          fetch_resp_o,
  output l2_req_t              l2_req_o,
  input  wire logic            l2_ready_i,
  input  wire l2_resp_t        l2_resp_i,
  output icache_mem_ctrl_t     mem_ctrl_o,
  output icache_idx_t          cache_idx_o,   // shared sram index
  output icache_vtag_t         vtag_wdata_o,
  output icache_tag_t          req_tag_o,     // to way selector
  output icache_woff_t         req_word_o,
  input  wire icache_way_sel_t way_sel_i
);

  typedef enum logic [2:0] {
    FLUSH,
    IDLE,
    COMPARE,
    L2_REQ,
    L2_WAIT,
    REFILL
  } icache_state_e;

  icache_state_e                   state_q, state_d;
  icache_idx_t                     flush_idx_q;    // sweep pointer
  icache_way_t [ICACHE_SETS-1:0]   lru_q;          // mru way per set
  logic [1:0]                      drop_cnt_q;     // aborted l2 answers still due
  icache_addr_t                    req_addr_q;     // latched fetch address
  icache_word_t                    refill_word_q;  // word picked off the l2 line

  icache_idx_t req_idx;
  icache_way_t victim;
  logic        accept;
  logic        resp_live;
  logic        resp_stale;
  logic        refill_we;
  logic        drop_inc;
  logic        flush_done;

  assign req_idx    = addr_idx(req_addr_q);
  assign req_tag_o  = addr_tag(req_addr_q);
  assign req_word_o = addr_woff(req_addr_q);
  assign victim     = ~lru_q[req_idx];  // not most recently used
  assign accept     = fetch_req_i.valid && ready_o;
  assign flush_done = (flush_idx_q == icache_idx_t'(ICACHE_SETS - 1));

  // an answer to an aborted miss must not land in a later one
  assign resp_live  = l2_resp_i.valid && (drop_cnt_q == '0);
  assign resp_stale = l2_resp_i.valid && (drop_cnt_q != '0);
  assign refill_we  = (state_q == L2_WAIT) && resp_live && !abort_i;
  assign drop_inc   = (state_q == L2_WAIT) && abort_i && !resp_live;

  always_comb begin : ready_logic
    case (state_q)
      IDLE:    ready_o = !flush_i;
      COMPARE: ready_o = way_sel_i.hit && !flush_i;  // hits stream
      REFILL:  ready_o = 1'b1;
      default: ready_o = 1'b0;
    endcase
  end

  always_comb begin : next_state
    state_d = state_q;
    case (state_q)
      FLUSH: begin
        if (flush_done) state_d = IDLE;
      end
      IDLE: begin
        if (flush_i) state_d = FLUSH;
        else if (accept) state_d = COMPARE;
      end
      COMPARE: begin
        if (flush_i) state_d = FLUSH;
        else if (!way_sel_i.hit) state_d = L2_REQ;  // miss
        else if (accept) state_d = COMPARE;
        else state_d = IDLE;
      end
      L2_REQ: begin
        if (l2_ready_i) state_d = L2_WAIT;  // request taken
      end
      L2_WAIT: begin
        if (abort_i) state_d = IDLE;
        else if (resp_live) state_d = REFILL;
      end
      REFILL: begin
        state_d = accept ? COMPARE : IDLE;
      end
      default: state_d = FLUSH;
    endcase
  end

  // front end and l2 channels
  always_comb begin : chan_out
    fetch_resp_o.valid = ((state_q == COMPARE) && way_sel_i.hit) || (state_q == REFILL);
    fetch_resp_o.data  = (state_q == REFILL) ? refill_word_q : way_sel_i.word;
    l2_req_o.valid     = (state_q == L2_REQ);  // held until l2_ready_i
    l2_req_o.line_addr = req_addr_q[ADDR_LEN-1:OFFSET_LEN];
  end

  // sram strobes, index and vtag write data
  always_comb begin : mem_out
    mem_ctrl_o   = '0;
    cache_idx_o  = addr_idx(fetch_req_i.addr);  // read on acceptance
    vtag_wdata_o = '{valid: 1'b1, tag: req_tag_o};
    if (state_q == FLUSH) begin
      mem_ctrl_o.tag_cs = '1;  // invalidate all ways
      mem_ctrl_o.tag_we = '1;
      cache_idx_o       = flush_idx_q;
      vtag_wdata_o      = '0;
    end else if (refill_we) begin
      mem_ctrl_o.tag_cs[victim]  = 1'b1;
      mem_ctrl_o.tag_we[victim]  = 1'b1;
      mem_ctrl_o.data_cs[victim] = 1'b1;
      mem_ctrl_o.data_we[victim] = 1'b1;
      cache_idx_o                = req_idx;
    end else if (accept) begin
      mem_ctrl_o.tag_cs  = '1;
      mem_ctrl_o.data_cs = '1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin : ctrl_regs
    if (!arst_n_i) begin
      state_q     <= FLUSH;  // tag srams hold garbage
      flush_idx_q <= '0;
      lru_q       <= '0;
      drop_cnt_q  <= '0;
    end else begin
      state_q     <= state_d;
      flush_idx_q <= (state_q == FLUSH) ? flush_idx_q + 1'b1 : '0;
      if (state_q == FLUSH) begin
        lru_q <= '0;
      end else if ((state_q == COMPARE) && way_sel_i.hit) begin
        lru_q[req_idx] <= way_sel_i.way;
      end else if (refill_we) begin
        lru_q[req_idx] <= victim;  // refilled way now mru
      end
      drop_cnt_q <= drop_cnt_q + {1'b0, drop_inc} - {1'b0, resp_stale};
    end
  end

  always_ff @(posedge clk_i) begin : payload_regs
    if (accept) begin
      req_addr_q <= fetch_req_i.addr;
    end
    if (refill_we) begin
      refill_word_q <= l2_resp_i.line[req_word_o];
    end
  end

endmodule

`default_nettype wire

// File: src/icache_l1_with_ssram.sv
// l1 instruction cache top
// controller, per-way srams, way selector
`timescale 1ns/100ps
`default_nettype none

module icache_l1_with_ssram
  import icache_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     arst_n_i,
  input  wire logic     flush_i,       // invalidate every line
  input  wire logic     abort_i,       // drop pending miss
  input  wire fetch_req_t fetch_req_i, // front-end fetch request
  output logic          ready_o,
  output fetch_resp_t   fetch_resp_o,
  output l2_req_t       l2_req_o,      // line request to l2
  input  wire logic     l2_ready_i,
  input  wire l2_resp_t l2_resp_i
);

  icache_mem_ctrl_t mem_ctrl;
  icache_idx_t      cache_idx;
  icache_vtag_t     vtag_wdata;
  icache_tag_t      req_tag;
  icache_woff_t     req_word;
  icache_way_sel_t  way_sel;

  // one driver per way element
  wire icache_vtag_t [ICACHE_WAYS-1:0] vtag_rdata;
  wire icache_line_t [ICACHE_WAYS-1:0] line_rdata;

  icache_ctrl ctrl0 (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .flush_i      (flush_i),
    .abort_i      (abort_i),
    .fetch_req_i  (fetch_req_i),
    .ready_o      (ready_o),
    .fetch_resp_o (fetch_resp_o),
    .l2_req_o     (l2_req_o),
    .l2_ready_i   (l2_ready_i),
    .l2_resp_i    (l2_resp_i),
    .mem_ctrl_o   (mem_ctrl),
    .cache_idx_o  (cache_idx),
    .vtag_wdata_o (vtag_wdata),
    .req_tag_o    (req_tag),
    .req_word_o   (req_word),
    .way_sel_i    (way_sel)
  );

  // valid + tag, one sram per way
  for (genvar k = 0; k < ICACHE_WAYS; k++) begin : vtag_block
    ssram #(
      .NUM_WORDS (ICACHE_SETS),
      .DATA_LEN  (VTAG_LEN)
    ) vtag_ssram (
      .clk_i   (clk_i),
      .cs_i    (mem_ctrl.tag_cs[k]),
      .we_i    (mem_ctrl.tag_we[k]),
      .addr_i  (cache_idx),
      .wdata_i (vtag_wdata),
      .rdata_o (vtag_rdata[k])
    );
  end

  // line data, written straight from l2
  for (genvar k = 0; k < ICACHE_WAYS; k++) begin : line_block
    ssram #(
      .NUM_WORDS (ICACHE_SETS),
      .DATA_LEN  (ICACHE_LINE_LEN)
    ) data_ssram (
      .clk_i   (clk_i),
      .cs_i    (mem_ctrl.data_cs[k]),
      .we_i    (mem_ctrl.data_we[k]),
      .addr_i  (cache_idx),
      .wdata_i (l2_resp_i.line),
      .rdata_o (line_rdata[k])
    );
  end

  icache_way_select sel0 (
    .vtag_i     (vtag_rdata),
    .line_i     (line_rdata),
    .req_tag_i  (req_tag),
    .req_word_i (req_word),
    .way_sel_o  (way_sel)
  );

endmodule

`default_nettype wire

// File: bench/icache_assert_chk.sv
// icache controller assertions
`timescale 1ns/100ps
`default_nettype none

module icache_assert_chk
  import icache_pkg::*;
(
  input wire logic             clk_i,
  input wire logic             arst_n_i,
  input wire logic             ready_i,
  input wire logic             miss_i,       // compare found no hit
  input wire logic             resp_valid_i, // front-end response pulse
  input wire logic             abort_i,
  input wire l2_req_t          l2_req_i,
  input wire logic             l2_ready_i,
  input wire icache_mem_ctrl_t mem_ctrl_i
);

  int   fail_cnt = 0;  // failed assertion count
  logic miss_pend_q;   // miss seen, no answer or abort yet

  always_ff @(posedge clk_i or negedge arst_n_i) begin : miss_track
    if (!arst_n_i) begin
      miss_pend_q <= 1'b0;
    end else if (resp_valid_i || abort_i) begin
      miss_pend_q <= 1'b0;
    end else if (miss_i) begin
      miss_pend_q <= 1'b1;
    end
  end

  // request held and stable until taken
  a_l2_req_hold : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (l2_req_i.valid && !l2_ready_i) |=> (l2_req_i.valid && $stable(l2_req_i.line_addr)))
    else begin
      $error("l2 request dropped or changed before l2_ready_i");
      fail_cnt++;
    end

  // front end held off from miss detection until its answer
  a_miss_not_ready : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ((miss_i || miss_pend_q) && !resp_valid_i) |-> !ready_i)
    else begin
      $error("ready_o high while a miss is outstanding");
      fail_cnt++;
    end

  a_we_needs_cs : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ((mem_ctrl_i.tag_we & ~mem_ctrl_i.tag_cs) == '0) &&
    ((mem_ctrl_i.data_we & ~mem_ctrl_i.data_cs) == '0))
    else begin
      $error("sram write enable without chip select");
      fail_cnt++;
    end

endmodule

bind icache_ctrl icache_assert_chk chk0 (
  .clk_i        (clk_i),
  .arst_n_i     (arst_n_i),
  .ready_i      (ready_o),
  .miss_i       ((state_q == COMPARE) && !way_sel_i.hit),
  .resp_valid_i (fetch_resp_o.valid),
  .abort_i      (abort_i),
  .l2_req_i     (l2_req_o),
  .l2_ready_i   (l2_ready_i),
  .mem_ctrl_i   (mem_ctrl_o)
);

`default_nettype wire

// File: bench/icache_monitor.sv
// icache response checker
// reference words, lru and tag shadow
`timescale 1ns/100ps
`default_nettype none

module icache_monitor
  import icache_pkg::*;
(
  input wire logic        clk_i,
  input wire logic        arst_n_i,
  input wire logic        flush_i,
  input wire logic        abort_i,
  input wire fetch_req_t  fetch_req_i,
  input wire logic        ready_i,
  input wire fetch_resp_t fetch_resp_i,
  input wire l2_req_t     l2_req_i,
  input wire logic        l2_ready_i
);

  typedef struct packed {
    icache_addr_t addr;
    logic         miss;     // predicted by shadow
    logic         l2_seen;
    logic [31:0]  cyc;      // acceptance cycle
  } pend_t;

  pend_t       pend_q [$];
  icache_tag_t sh_tag [ICACHE_SETS][ICACHE_WAYS];
  logic        sh_vld [ICACHE_SETS][ICACHE_WAYS];
  icache_way_t sh_mru [ICACHE_SETS];
  int          err_cnt, test_cnt, test_err, test_resp, test_l2;
  int          flush_left;
  logic        abort_chk;
  logic [31:0] cyc;

  // word at byte address, xor key as the l2 side stores it
  function automatic icache_word_t expected_word(icache_addr_t a);
    return {a[31:2], 2'b00} ^ 32'h5A3C_96E1;
  endfunction

  task automatic report(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    err_cnt++;
    test_err++;
  endtask

  task automatic end_test(input string name);
    $display("test %-10s responses %0d  l2 requests %0d  errors %0d  %s",
             name, test_resp, test_l2, test_err, (test_err == 0) ? "ok" : "failed");
    test_cnt++;
    test_err  = 0;
    test_resp = 0;
    test_l2   = 0;
  endtask

  task automatic shadow_clear();
    for (int s = 0; s < ICACHE_SETS; s++) begin
      sh_mru[s] = '0;
      for (int w = 0; w < ICACHE_WAYS; w++) sh_vld[s][w] = 1'b0;
    end
  endtask

  initial begin
    err_cnt  = 0;
    test_cnt = 0;
    test_err = 0;
    test_resp = 0;
    test_l2  = 0;
    cyc      = 0;
  end

  always @(negedge clk_i) begin : compare
    pend_t       p;
    icache_idx_t s;
    icache_way_t v;
    logic        hit;
    cyc++;
    if (!arst_n_i) begin
      pend_q.delete();
      shadow_clear();
      flush_left = 0;
      abort_chk  = 1'b0;
    end else begin
      if (abort_chk && !ready_i) report("ready_o stayed low after abort");
      abort_chk = 1'b0;
      if (flush_left > 0) begin
        if (ready_i) report("ready_o high during flush sweep");
        flush_left--;
      end
      if (flush_i) begin
        shadow_clear();
        flush_left = ICACHE_SETS;
      end
      if (l2_req_i.valid && l2_ready_i) begin   // l2 takes request at next edge
        test_l2++;
        if (pend_q.size() == 0 || !pend_q[0].miss) report("unexpected L2 request");
        else if (l2_req_i.line_addr != addr_line(pend_q[0].addr))
          report($sformatf("L2 line address %h expected %h",
                           l2_req_i.line_addr, addr_line(pend_q[0].addr)));
        else pend_q[0].l2_seen = 1'b1;
      end
      if (fetch_resp_i.valid) begin
        if (pend_q.size() == 0) begin
          report("response pulse with no request pending");
        end else begin
          p = pend_q.pop_front();
          test_resp++;
          if (fetch_resp_i.data != expected_word(p.addr))
            report($sformatf("addr %h data %h expected %h", p.addr,
                             fetch_resp_i.data, expected_word(p.addr)));
          if (!p.miss && cyc != p.cyc + 1) report("hit response not one cycle after request");
          if (p.miss) begin
            if (!p.l2_seen) report("miss answered without an L2 request");
            s = p.addr[7:4];
            v = ~sh_mru[s];   // victim is the lru way
            sh_vld[s][v] = 1'b1;
            sh_tag[s][v] = p.addr[31:8];
            sh_mru[s]    = v;
          end
        end
      end
      if (abort_i && pend_q.size() != 0) begin
        p = pend_q.pop_front();   // dropped, nothing installed
        abort_chk = 1'b1;
      end
      if (fetch_req_i.valid && ready_i) begin
        s   = fetch_req_i.addr[7:4];
        hit = 1'b0;
        for (int w = ICACHE_WAYS - 1; w >= 0; w--) begin
          if (sh_vld[s][w] && sh_tag[s][w] == fetch_req_i.addr[31:8]) begin
            hit = 1'b1;
            v   = icache_way_t'(w);
          end
        end
        if (hit) sh_mru[s] = v;
        pend_q.push_back('{addr: fetch_req_i.addr, miss: !hit, l2_seen: 1'b0, cyc: cyc});
      end
    end
  end

  function automatic icache_laddr_t addr_line(icache_addr_t a);
    return a[31:4];
  endfunction

endmodule

`default_nettype wire

// File: bench/tb_icache.sv
// icache testbench top
// clock, reset, stimulus, l2 memory model
`timescale 1ns/100ps
`default_nettype none

module tb_icache
  import icache_pkg::*;
;

  localparam int NUM_RAND   = 40;
  localparam int NUM_STREAM = 9;   // fill plus 8 hits
  localparam int NUM_REPL   = 12;
  localparam int NUM_BP     = 6;
  localparam int NUM_REQ    = NUM_RAND + NUM_STREAM + NUM_REPL + 2 + 2 + NUM_BP;
  localparam int TIMEOUT_CYCLES = NUM_REQ * 20 + 2 * ICACHE_SETS + 200;
  localparam logic [31:0] WORD_KEY = 32'h5A3C_96E1;  // l2 content scramble

  logic        clk;
  logic        arst_n;
  logic        flush;
  logic        abort;
  logic        l2_ready;
  logic        bp_mode;   // long l2 back-pressure
  logic        ready;
  fetch_req_t  fetch_req;
  fetch_resp_t fetch_resp;
  l2_req_t     l2_req;
  l2_resp_t    l2_resp;
  int          seed = 55;

  icache_l1_with_ssram dut0 (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .flush_i      (flush),
    .abort_i      (abort),
    .fetch_req_i  (fetch_req),
    .ready_o      (ready),
    .fetch_resp_o (fetch_resp),
    .l2_req_o     (l2_req),
    .l2_ready_i   (l2_ready),
    .l2_resp_i    (l2_resp)
  );

  icache_monitor mon0 (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .flush_i      (flush),
    .abort_i      (abort),
    .fetch_req_i  (fetch_req),
    .ready_i      (ready),
    .fetch_resp_i (fetch_resp),
    .l2_req_i     (l2_req),
    .l2_ready_i   (l2_ready)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // l2 line: each word is its byte address xor a key
  function automatic icache_line_t l2_line(icache_laddr_t la);
    icache_line_t line;
    for (int i = 0; i < ICACHE_LINE_WORDS; i++) begin
      line[i] = {la, 2'(i), 2'b00} ^ WORD_KEY;
    end
    return line;
  endfunction

  // small tag pool over sets 0..3 so lines conflict
  function automatic icache_addr_t rand_addr();
    logic [31:0] r;
    r = $random(seed);
    return {24'h00C0DE + 24'(r[1:0]), 4'(r[3:2]), r[5:4], 2'b00};
  endfunction

  initial begin : l2_model
    icache_laddr_t la;
    int            dly;
    forever begin
      @(negedge clk);
      if (l2_req.valid) begin
        la  = l2_req.line_addr;
        dly = bp_mode ? 8 + ($random(seed) & 7) : ($random(seed) & 3);
        @(posedge clk);
        repeat (dly) @(posedge clk);
        l2_ready <= 1'b1;   // accepted at the next edge
        @(posedge clk);
        l2_ready <= 1'b0;
        repeat (1 + ($random(seed) & 3)) @(posedge clk);
        l2_resp <= '{valid: 1'b1, line: l2_line(la)};
        @(posedge clk);
        l2_resp.valid <= 1'b0;
      end
    end
  end

  // present a request and hold it until taken
  task automatic fetch(input icache_addr_t a);
    fetch_req <= '{valid: 1'b1, addr: a};
    do @(negedge clk); while (!ready);
    @(posedge clk);
  endtask

  // drop the request and wait for every response
  task automatic drain();
    fetch_req.valid <= 1'b0;
    do @(negedge clk); while (mon0.pend_q.size() != 0 || !ready);
    @(posedge clk);
  endtask

  initial begin : stimulus
    icache_addr_t  a;
    logic [1:0]    pat [NUM_REPL] = '{0, 1, 0, 2, 1, 0, 2, 2, 1, 0, 1, 2};
    int            errs;
    fetch_req = '0;
    flush     = 1'b0;
    abort     = 1'b0;
    l2_ready  = 1'b0;
    l2_resp   = '0;
    bp_mode   = 1'b0;
    arst_n    = 1'b0;
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    drain();   // reset sweep
    for (int i = 0; i < NUM_RAND; i++) fetch(rand_addr());
    drain();
    mon0.end_test("data");
    a = 32'h0077_7050;
    for (int i = 0; i < NUM_STREAM; i++) fetch({a[31:4], 2'(i), 2'b00});  // fill then hits
    drain();
    mon0.end_test("stream");
    for (int i = 0; i < NUM_REPL; i++) fetch({24'h00BEE0 + 24'(pat[i]), 4'd9, 4'h4});
    drain();
    mon0.end_test("replace");
    @(posedge clk);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    drain();
    fetch(a);   // was cached, must miss now
    fetch(a + 32'h4);
    drain();
    mon0.end_test("flush");
    a = 32'h0ABC_DE38;
    fetch(a);
    fetch_req.valid <= 1'b0;
    do @(negedge clk); while (!(l2_req.valid && l2_ready));
    @(posedge clk);
    abort <= 1'b1;   // first l2 wait cycle
    @(posedge clk);
    abort <= 1'b0;
    drain();
    fetch(a);
    drain();
    mon0.end_test("abort");
    bp_mode <= 1'b1;
    for (int i = 0; i < NUM_BP; i++) fetch({24'h00F00D + 24'(i), 4'd12, 4'h8});
    drain();
    bp_mode <= 1'b0;
    mon0.end_test("backpress");
    errs = mon0.err_cnt + dut0.ctrl0.chk0.fail_cnt;  // monitor plus assertions
    $display("tests %0d  errors %0d", mon0.test_cnt, errs);
    if (errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    int unsigned cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: no end of test after %0d cycles", cycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
src/icache_pkg.sv
src/ssram.sv
src/icache_way_select.sv
src/icache_ctrl.sv
src/icache_l1_with_ssram.sv
bench/icache_assert_chk.sv
bench/icache_monitor.sv
bench/tb_icache.sv

// File: Bender.yml
package:
  name: icache_l1

sources:
  - src/icache_pkg.sv
  - src/ssram.sv
  - src/icache_way_select.sv
  - src/icache_ctrl.sv
  - src/icache_l1_with_ssram.sv
  - target: test
    files:
      - bench/icache_assert_chk.sv
      - bench/icache_monitor.sv
      - bench/tb_icache.sv
